/* ads_cmd_pkg.sv */
// Converter protocol types
// Host control code, request struct, opcodes and command bytes
`default_nettype none

package ads_cmd_pkg;

  // Host control code, values 4 to 7 behave as IDLE
  typedef enum logic [2:0] {
    CTRL_IDLE   = 3'd0,
    CTRL_SYSCMD = 3'd1,
    CTRL_WREG   = 3'd2,
    CTRL_RREG   = 3'd3
  } ads_ctrl_e;

  // Host request as one level
  typedef struct packed {
    ads_ctrl_e   ctrl;              // Operation select
    logic [7:0]  cmd;               // System command byte
    logic [4:0]  addr;              // Register address
    logic [7:0]  wdata;             // Register write data
  } ads_req_t;

  //////////////////////////////
  // System command bytes
  localparam logic [7:0] CMD_RESET = 8'h06;   // Done on the reset pin
  localparam logic [7:0] CMD_START = 8'h08;   // Done on the start pin
  localparam logic [7:0] CMD_STOP  = 8'h0A;   // Done on the start pin

  // Register access opcodes
  localparam logic [2:0] OP_RREG    = 3'b001;  // 001a_aaaa
  localparam logic [2:0] OP_WREG    = 3'b010;  // 010a_aaaa
  localparam logic [7:0] REG_COUNT  = 8'h00;   // One register per access
  localparam logic [7:0] DUMMY_BYTE = 8'h00;   // Clocks the read data out

endpackage

`default_nettype wire

/* ads_cmd_sequencer.sv */
// Command sequencer for the ADS converter
// Pin commands, SPI byte sequences, csn framing and register read results
// One hold counter times both the reset pulse and the csn hold
`timescale 1ns/1ps
`default_nettype none
`include "ads_macros.svh"

module ads_cmd_sequencer
  import spi_link_pkg::*;
  import ads_cmd_pkg::*;
(
  input  wire           clk,
  input  wire           rstn,
  input  wire ads_req_t i_req,          // Registered host request
  input  wire           i_tx_ready,     // SPI master free
  input  wire spi_rx_t  i_rx,           // Received byte strobe
  output logic          o_idle,         // Operands may load
  output spi_tx_t       o_tx,           // Byte to the SPI master
  output logic          o_busy,
  output logic          o_rd_valid,     // One cycle read result
  output spi_byte_t     o_rd_data,
  output logic          o_ads_start,    // Converter START pin
  output logic          o_ads_resetn,   // Converter RESET pin, active low
  output logic          o_spi_csn
);

  localparam int HOLD_MAX = (`CS_HOLD_CYCLES > `RESET_PULSE_CYCLES) ?
                            `CS_HOLD_CYCLES : `RESET_PULSE_CYCLES;
  localparam int HOLD_W   = (HOLD_MAX > 1) ? $clog2(HOLD_MAX) : 1;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_PIN,                             // START or STOP pin set
    ST_RESET_PULSE,
    ST_SEND,                            // Wait for the master, then strobe
    ST_WAIT_BYTE,
    ST_CS_HOLD
  } state_e;

  state_e            state;
  ads_ctrl_e         op_q;              // Operation in progress
  logic [1:0]        byte_idx;          // Byte within the frame
  logic [1:0]        last_idx;
  logic [HOLD_W-1:0] hold_cnt;
  spi_byte_t         tx_byte;
  logic              is_syscmd;

  assign o_idle    = (state == ST_IDLE);
  assign is_syscmd = (i_req.ctrl == CTRL_SYSCMD);
  assign last_idx  = (op_q == CTRL_SYSCMD) ? 2'd0 : 2'd2;   // 1 or 3 bytes

  //////////////////////////////
  // Next byte of the frame
  always_comb begin
    case (byte_idx)
      2'd0: begin
        if (op_q == CTRL_SYSCMD) begin
          tx_byte = i_req.cmd;
        end else begin
          tx_byte = {(op_q == CTRL_RREG) ? OP_RREG : OP_WREG, i_req.addr};
        end
      end
      2'd1:    tx_byte = REG_COUNT;
      default: tx_byte = (op_q == CTRL_WREG) ? i_req.wdata : DUMMY_BYTE;
    endcase
  end

  assign o_tx = '{send: (state == ST_SEND) && i_tx_ready, data: tx_byte};

  //////////////////////////////
  // Main FSM
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state        <= ST_IDLE;
      op_q         <= CTRL_IDLE;
      byte_idx     <= '0;
      hold_cnt     <= '0;
      o_busy       <= 1'b0;
      o_rd_valid   <= 1'b0;
      o_rd_data    <= '0;
      o_ads_start  <= 1'b0;
      o_ads_resetn <= 1'b1;
      o_spi_csn    <= 1'b1;
    end else begin
      o_rd_valid <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (i_req.ctrl != CTRL_IDLE) begin
            o_busy   <= 1'b1;
            op_q     <= i_req.ctrl;
            byte_idx <= '0;
            if (is_syscmd && i_req.cmd == CMD_START) begin
              o_ads_start <= 1'b1;
              state       <= ST_PIN;
            end else if (is_syscmd && i_req.cmd == CMD_STOP) begin
              o_ads_start <= 1'b0;
              state       <= ST_PIN;
            end else if (is_syscmd && i_req.cmd == CMD_RESET) begin
              o_ads_resetn <= 1'b0;
              hold_cnt     <= HOLD_W'(`RESET_PULSE_CYCLES - 1);
              state        <= ST_RESET_PULSE;
            end else begin
              o_spi_csn <= 1'b0;                 // Frame opens with busy
              state     <= ST_SEND;
            end
          end
        end
        ST_PIN: begin
          o_busy <= 1'b0;
          state  <= ST_IDLE;
        end
        ST_RESET_PULSE: begin
          if (hold_cnt == '0) begin
            o_ads_resetn <= 1'b1;
            o_busy       <= 1'b0;
            state        <= ST_IDLE;
          end else begin
            hold_cnt <= hold_cnt - 1'b1;
          end
        end
        ST_SEND: begin
          if (i_tx_ready) state <= ST_WAIT_BYTE;  // Strobe goes out now
        end
        ST_WAIT_BYTE: begin
          if (i_rx.valid) begin
            if (byte_idx == last_idx) begin
              hold_cnt <= HOLD_W'(`CS_HOLD_CYCLES - 1);
              state    <= ST_CS_HOLD;
              if (op_q == CTRL_RREG) begin
                o_rd_valid <= 1'b1;              // Byte seen during the dummy
                o_rd_data  <= i_rx.data;
              end
            end else begin
              byte_idx <= byte_idx + 1'b1;
              state    <= ST_SEND;
            end
          end
        end
        ST_CS_HOLD: begin
          if (hold_cnt == '0) begin
            o_spi_csn <= 1'b1;
            o_busy    <= 1'b0;
            state     <= ST_IDLE;
          end else begin
            hold_cnt <= hold_cnt - 1'b1;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  //////////////////////////////
  // Checks
  a_csn_within_busy : assert property (
    @(posedge clk) disable iff (!rstn) !o_spi_csn |-> o_busy
  ) else $error("ads_cmd_sequencer: csn low outside an operation");

  a_rd_valid_in_read : assert property (
    @(posedge clk) disable iff (!rstn) o_rd_valid |-> (op_q == CTRL_RREG) && o_busy
  ) else $error("ads_cmd_sequencer: read valid outside a register read");

  a_reset_pulse_len : assert property (
    @(posedge clk) disable iff (!rstn)
      $fell(o_ads_resetn) |-> ##[1:`RESET_PULSE_CYCLES] o_ads_resetn
  ) else $error("ads_cmd_sequencer: reset pin held low too long");

endmodule

`default_nettype wire

/* ads_ctrl_top.sv */
// Top level of the ADS command controller
// Request registers, command sequencer and mode 0 SPI master
`timescale 1ns/1ps
`default_nettype none
`include "ads_macros.svh"

module ads_ctrl_top
  import spi_link_pkg::*;
  import ads_cmd_pkg::*;
(
  input  wire           clk,
  input  wire           rstn,
  input  wire ads_req_t i_req,          // Host request level
  input  wire           i_spi_miso,
  output logic          o_busy,
  output logic          o_rd_valid,
  output spi_byte_t     o_rd_data,
  output logic          o_ads_start,
  output logic          o_ads_resetn,
  output logic          o_spi_csn,
  output logic          o_spi_clk,
  output logic          o_spi_mosi
);

  ads_req_t req_q;                      // Registered request
  logic     seq_idle;
  logic     tx_ready;
  spi_tx_t  spi_tx;
  spi_rx_t  spi_rx;

  ads_request_regs i_req_regs (
    .clk    (clk),
    .rstn   (rstn),
    .i_req  (i_req),
    .i_idle (seq_idle),
    .o_req  (req_q)
  );

  ads_cmd_sequencer i_seq (
    .clk          (clk),
    .rstn         (rstn),
    .i_req        (req_q),
    .i_tx_ready   (tx_ready),
    .i_rx         (spi_rx),
    .o_idle       (seq_idle),
    .o_tx         (spi_tx),
    .o_busy       (o_busy),
    .o_rd_valid   (o_rd_valid),
    .o_rd_data    (o_rd_data),
    .o_ads_start  (o_ads_start),
    .o_ads_resetn (o_ads_resetn),
    .o_spi_csn    (o_spi_csn)
  );

  spi_byte_master #(
    .CLKS_PER_HALF_BIT (`CLKS_PER_HALF_BIT)
  ) i_spi (
    .clk        (clk),
    .rstn       (rstn),
    .i_tx       (spi_tx),
    .o_tx_ready (tx_ready),
    .o_rx       (spi_rx),
    .o_spi_clk  (o_spi_clk),
    .i_spi_miso (i_spi_miso),
    .o_spi_mosi (o_spi_mosi)
  );

endmodule

`default_nettype wire

/* ads_macros.svh */
// Timing constants for the ADS command controller
// SPI clock divide, chip select hold and reset pulse length
`ifndef ADS_MACROS_SVH
`define ADS_MACROS_SVH

// System clocks per half SPI bit, at least 2
`define CLKS_PER_HALF_BIT 4

// Cycles csn stays low after the last byte
`define CS_HOLD_CYCLES 8

`define RESET_PULSE_CYCLES 4   // Low time of the converter reset pin

`endif

/* ads_request_regs.sv */
// Host request registers
// Control code sampled every cycle, operands held while an operation runs
`timescale 1ns/1ps
`default_nettype none

module ads_request_regs
  import ads_cmd_pkg::*;
(
  input  wire           clk,
  input  wire           rstn,
  input  wire ads_req_t i_req,          // Host level request
  input  wire           i_idle,         // Sequencer can accept operands
  output ads_req_t      o_req
);

  ads_ctrl_e  ctrl_q;
  logic [7:0] cmd_q;
  logic [4:0] addr_q;
  logic [7:0] wdata_q;

  // Control code, unknown codes fold to IDLE
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      ctrl_q <= CTRL_IDLE;
    end else begin
      case (i_req.ctrl)
        CTRL_SYSCMD, CTRL_WREG, CTRL_RREG: ctrl_q <= i_req.ctrl;
        default:                           ctrl_q <= CTRL_IDLE;
      endcase
    end
  end

  // Operands frozen once the sequencer leaves idle
  always_ff @(posedge clk) begin
    if (i_idle) begin
      cmd_q   <= i_req.cmd;
      addr_q  <= i_req.addr;
      wdata_q <= i_req.wdata;
    end
  end

  assign o_req = '{ctrl: ctrl_q, cmd: cmd_q, addr: addr_q, wdata: wdata_q};

endmodule

`default_nettype wire

/* files.f */
+incdir+.
spi_link_pkg.sv
ads_cmd_pkg.sv
spi_byte_master.sv
ads_request_regs.sv
ads_cmd_sequencer.sv
ads_ctrl_top.sv
tb_ads_ctrl.sv

/* run.sh */
#!/bin/sh
# Build and run the ADS command controller testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_ads_ctrl \
  -f files.f \
  -o sim_ads_ctrl

./obj_dir/sim_ads_ctrl | tee sim.log

if grep -q "TESTS FAILED" sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi
echo "Simulation finished without failures"

/* spi_byte_master.sv */
// SPI master, mode 0 only
// One byte out on MOSI and one byte in from MISO per send strobe
// Chip select is left to the caller
`timescale 1ns/1ps
`default_nettype none

module spi_byte_master
  import spi_link_pkg::*;
#(
  parameter int CLKS_PER_HALF_BIT = 4     // At least 2
) (
  input  wire          clk,
  input  wire          rstn,
  input  wire spi_tx_t i_tx,              // Send strobe and byte
  output logic         o_tx_ready,        // High when a new byte may start
  output spi_rx_t      o_rx,              // Received strobe and byte
  output logic         o_spi_clk,
  input  wire          i_spi_miso,
  output logic         o_spi_mosi
);

  localparam int HALF_W = (CLKS_PER_HALF_BIT > 1) ? $clog2(CLKS_PER_HALF_BIT) : 1;
  localparam logic [HALF_W-1:0] HALF_LAST = HALF_W'(CLKS_PER_HALF_BIT - 1);

  logic              active;              // Byte in flight
  logic [HALF_W-1:0] half_cnt;            // Clocks within the half bit
  logic [4:0]        edge_cnt;            // SCLK edges still to come
  logic [7:0]        tx_shift;            // MSB drives MOSI
  logic [7:0]        rx_shift;            // MISO bits, LSB newest
  logic              rx_valid;
  logic              half_done;

  assign half_done  = active && (half_cnt == HALF_LAST);
  assign o_tx_ready = !active;
  assign o_spi_mosi = tx_shift[7];
  assign o_rx       = '{valid: rx_valid, data: rx_shift};

  //////////////////////////////
  // Clock divider and edge sequencing
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      active    <= 1'b0;
      half_cnt  <= '0;
      edge_cnt  <= '0;
      o_spi_clk <= 1'b0;
      tx_shift  <= '0;
      rx_valid  <= 1'b0;
    end else begin
      rx_valid <= 1'b0;                   // Pulse only
      if (i_tx.send && !active) begin
        active   <= 1'b1;
        half_cnt <= '0;
        edge_cnt <= 5'd16;                // 8 rising and 8 falling
        tx_shift <= i_tx.data;            // Bit 7 on MOSI at once
      end else if (active) begin
        half_cnt <= half_done ? '0 : half_cnt + 1'b1;
        if (half_done) begin
          o_spi_clk <= !o_spi_clk;
          edge_cnt  <= edge_cnt - 1'b1;
          if (o_spi_clk) begin
            // Falling edge moves the next bit onto MOSI
            tx_shift <= {tx_shift[6:0], 1'b0};
            if (edge_cnt == 5'd1) begin
              active   <= 1'b0;           // Ready again with the strobe
              rx_valid <= 1'b1;
            end
          end
        end
      end
    end
  end

  // MISO sampled as SCLK rises
  always_ff @(posedge clk) begin
    if (half_done && !o_spi_clk) begin
      rx_shift <= {rx_shift[6:0], i_spi_miso};
    end
  end

  //////////////////////////////
  // Protocol checks
  a_no_send_while_busy : assert property (
    @(posedge clk) disable iff (!rstn) i_tx.send |-> o_tx_ready
  ) else $error("spi_byte_master: send strobe while a byte is in flight");

  a_sclk_idle_low : assert property (
    @(posedge clk) disable iff (!rstn) o_tx_ready |-> !o_spi_clk
  ) else $error("spi_byte_master: SCLK high while idle");

endmodule

`default_nettype wire

/* spi_link_pkg.sv */
// Serial link types
// Byte type plus transmit and receive byte structs for the SPI master
`default_nettype none

package spi_link_pkg;

  typedef logic [7:0] spi_byte_t;   // One serial byte

  // Byte handed to the SPI master
  typedef struct packed {
    logic      send;                // One cycle send strobe
    spi_byte_t data;                // Byte for MOSI, MSB first
  } spi_tx_t;

  // Byte returned by the SPI master
  typedef struct packed {
    logic      valid;               // One cycle received strobe
    spi_byte_t data;                // Byte collected from MISO
  } spi_rx_t;

endpackage

`default_nettype wire

/* tb_ads_ctrl.sv */
// Testbench for the ADS command controller
// Clock and reset, converter serial model with 32 registers
// Directed tests for pin commands, SPI commands and register access
`timescale 1ns/1ps
`default_nettype none
`include "ads_macros.svh"

module tb_ads_ctrl
  import spi_link_pkg::*;
  import ads_cmd_pkg::*;
();

  localparam int CLK_PERIOD  = 40;
  localparam int NUM_PAIRS   = 8;                       // Write and read-back pairs
  localparam int BYTE_CYCLES = 16 * `CLKS_PER_HALF_BIT + 4;
  localparam int OP_CYCLES   = 3 * BYTE_CYCLES + `CS_HOLD_CYCLES + 10;  // Longest operation
  localparam int NUM_OPS     = 2 * NUM_PAIRS + 6;
  localparam int WATCHDOG_NS = NUM_OPS * OP_CYCLES * CLK_PERIOD;       // Close to 200 us

  logic      clk;
  logic      rstn;
  ads_req_t  req;
  wire       spi_miso;
  logic      busy;
  logic      rd_valid;
  spi_byte_t rd_data;
  logic      ads_start;
  logic      ads_resetn;
  logic      spi_csn;
  logic      spi_clk;
  logic      spi_mosi;

  // Converter model state
  logic [7:0] model_regs [32];
  spi_byte_t  byte_log [$];          // Every byte seen on MOSI
  int         frame_cnt;             // csn falling edges
  spi_byte_t  rx_byte;
  spi_byte_t  op_byte;               // First byte of the frame
  spi_byte_t  miso_shift;
  int         bit_cnt;
  int         byte_pos;
  logic       clk_q;
  logic       csn_q;

  // Per operation records
  int         log_base;
  int         frame_base;
  int         resetn_low;
  int         csn_low;
  int         rd_valid_cnt;
  spi_byte_t  rd_data_seen;
  int         errors;
  int         checks;
  int         seed;

  ads_ctrl_top i_dut (
    .clk          (clk),
    .rstn         (rstn),
    .i_req        (req),
    .i_spi_miso   (spi_miso),
    .o_busy       (busy),
    .o_rd_valid   (rd_valid),
    .o_rd_data    (rd_data),
    .o_ads_start  (ads_start),
    .o_ads_resetn (ads_resetn),
    .o_spi_csn    (spi_csn),
    .o_spi_clk    (spi_clk),
    .o_spi_mosi   (spi_mosi)
  );

  assign spi_miso = miso_shift[7];   // MSB first

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  //////////////////////////////
  // Mode 0 converter serial model
  initial begin
    int i;
    for (i = 0; i < 32; i++) begin
      model_regs[i] = 8'(8'hA5 ^ (i * 7));   // Distinct value per address
    end
    frame_cnt  = 0;
    miso_shift = 8'h00;
    bit_cnt    = 0;
    byte_pos   = 0;
    clk_q      = 1'b0;
    csn_q      = 1'b1;
    forever begin
      @(spi_csn or spi_clk);
      if (!spi_csn && csn_q) begin
        frame_cnt++;                         // New frame
        bit_cnt    = 0;
        byte_pos   = 0;
        miso_shift = 8'h00;
      end else if (!spi_csn && spi_clk && !clk_q) begin
        rx_byte = {rx_byte[6:0], spi_mosi};  // Rising SCLK samples MOSI
        bit_cnt++;
        if (bit_cnt == 8) begin
          byte_log.push_back(rx_byte);
          if (byte_pos == 0) op_byte = rx_byte;
          if (byte_pos == 2 && op_byte[7:5] == 3'b010) begin
            model_regs[op_byte[4:0]] = rx_byte;
          end
          bit_cnt = 0;
          byte_pos++;
        end
      end else if (!spi_csn && !spi_clk && clk_q) begin
        if (bit_cnt != 0) begin
          miso_shift = {miso_shift[6:0], 1'b0};
        end else if (byte_pos == 2 && op_byte[7:5] == 3'b001) begin
          miso_shift = model_regs[op_byte[4:0]];   // Read data during the dummy byte
        end else begin
          miso_shift = 8'h00;
        end
      end
      csn_q = spi_csn;
      clk_q = spi_clk;
    end
  end

  //////////////////////////////
  // Helpers
  task automatic next_cycle();
    @(posedge clk);
    #2;                                // Drive and sample point
  endtask

  task automatic check_val(input string name, input logic [31:0] got,
                           input logic [31:0] want);
    checks++;
    assert (got === want) else begin
      errors++;
      $display("** Error: %s = %0h, expected %0h at %0t ns", name, got, want, $time);
    end
  endtask

  task automatic check_cond(input logic ok, input string what);
    checks++;
    assert (ok) else begin
      errors++;
      $display("Failure at %0t ns: %s", $time, what);
    end
  endtask

  task automatic clear_records();
    log_base     = byte_log.size();
    frame_base   = frame_cnt;
    resetn_low   = 0;
    csn_low      = 0;
    rd_valid_cnt = 0;
    rd_data_seen = 8'h00;
  endtask

  // Code held as a level until busy rises
  task automatic start_op(input ads_ctrl_e code, input logic [7:0] cmd,
                          input logic [4:0] addr, input logic [7:0] wdata);
    int n;
    req = '{ctrl: code, cmd: cmd, addr: addr, wdata: wdata};
    n   = 0;
    while (!busy && n < 8) begin
      next_cycle();
      n++;
    end
    req.ctrl = CTRL_IDLE;
    check_cond(busy, "o_busy did not rise after a control code");
  endtask

  task automatic finish_op();
    int n;
    n = 0;
    forever begin
      if (!ads_resetn) resetn_low++;
      if (!spi_csn) csn_low++;
      if (rd_valid) begin
        rd_valid_cnt++;
        rd_data_seen = rd_data;
      end
      if (!busy || n >= OP_CYCLES) break;
      next_cycle();
      n++;
    end
    check_cond(!busy, "operation did not end within the time limit");
  endtask

  task automatic run_op(input ads_ctrl_e code, input logic [7:0] cmd,
                        input logic [4:0] addr, input logic [7:0] wdata);
    start_op(code, cmd, addr, wdata);
    finish_op();
  endtask

  // Zero bytes means no frame at all
  task automatic check_frame(input int n, input spi_byte_t b0, input spi_byte_t b1,
                             input spi_byte_t b2);
    spi_byte_t want [3];
    int        got_n;
    int        i;
    want  = '{b0, b1, b2};
    got_n = byte_log.size() - log_base;
    check_val("csn frames", frame_cnt - frame_base, (n > 0) ? 1 : 0);
    check_val("logged bytes", got_n, n);
    for (i = 0; i < n && i < got_n; i++) begin
      check_val($sformatf("logged byte %0d", i), int'(byte_log[log_base + i]), int'(want[i]));
    end
  endtask

  //////////////////////////////
  // Directed tests
  task automatic test_reset_values();
    check_val("o_busy", busy, 0);
    check_val("o_rd_valid", rd_valid, 0);
    check_val("o_rd_data", rd_data, 0);
    check_val("o_ads_start", ads_start, 0);
    check_val("o_ads_resetn", ads_resetn, 1);
    check_val("o_spi_csn", spi_csn, 1);
    check_val("o_spi_clk", spi_clk, 0);
    check_val("o_spi_mosi", spi_mosi, 0);
  endtask

  task automatic test_start_stop();
    clear_records();
    run_op(CTRL_SYSCMD, CMD_START, 5'd0, 8'h00);
    check_val("o_ads_start", int'(ads_start), 1);
    check_val("csn low cycles", csn_low, 0);
    check_frame(0, 8'h00, 8'h00, 8'h00);
    clear_records();
    run_op(CTRL_SYSCMD, CMD_STOP, 5'd0, 8'h00);
    check_val("o_ads_start", int'(ads_start), 0);
    check_val("csn low cycles", csn_low, 0);
    check_frame(0, 8'h00, 8'h00, 8'h00);
  endtask

  task automatic test_reset_pulse();
    clear_records();
    run_op(CTRL_SYSCMD, CMD_RESET, 5'd0, 8'h00);
    check_val("o_ads_resetn low cycles", resetn_low, `RESET_PULSE_CYCLES);
    check_val("o_ads_resetn", int'(ads_resetn), 1);   // Back high as busy drops
    check_frame(0, 8'h00, 8'h00, 8'h00);
  endtask

  task automatic test_spi_syscmd();
    clear_records();
    run_op(CTRL_SYSCMD, 8'h10, 5'd0, 8'h00);
    check_frame(1, 8'h10, 8'h00, 8'h00);
  endtask

  task automatic test_write_read();
    logic [4:0] addr;
    logic [7:0] data;
    int         k;
    for (k = 0; k < NUM_PAIRS; k++) begin
      addr = 5'($random(seed));
      data = 8'($random(seed));
      clear_records();
      run_op(CTRL_WREG, 8'h00, addr, data);
      check_frame(3, {3'b010, addr}, 8'h00, data);
      check_val("model register", int'(model_regs[addr]), int'(data));
      check_val("o_rd_valid pulses", rd_valid_cnt, 0);
      clear_records();
      run_op(CTRL_RREG, 8'h00, addr, 8'h00);
      check_frame(3, {3'b001, addr}, 8'h00, 8'h00);
      check_val("o_rd_valid pulses", rd_valid_cnt, 1);
      check_val("o_rd_data", int'(rd_data_seen), int'(data));
    end
  endtask

  task automatic test_code_while_busy();
    int n;
    clear_records();
    start_op(CTRL_WREG, 8'h00, 5'd9, 8'h3C);
    repeat (3) next_cycle();
    req = '{ctrl: CTRL_SYSCMD, cmd: 8'h10, addr: 5'd4, wdata: 8'h77};  // Lands mid frame
    repeat (4) next_cycle();
    req.ctrl = CTRL_IDLE;
    check_cond(busy, "o_busy fell before the second code was cleared");
    finish_op();
    n = 0;
    repeat (10) begin
      next_cycle();
      if (busy) n++;
    end
    check_val("busy cycles after the operation", n, 0);
    check_frame(3, {3'b010, 5'd9}, 8'h00, 8'h3C);
    check_val("model register", int'(model_regs[9]), 'h3C);
  endtask

  //////////////////////////////
  // Main sequence
  initial begin
    seed   = 59;
    errors = 0;
    checks = 0;
    rstn   = 1'b0;
    req    = '0;
    repeat (4) @(posedge clk);
    #2;
    rstn = 1'b1;
    next_cycle();
    clear_records();
    test_reset_values();
    test_start_stop();
    test_reset_pulse();
    test_spi_syscmd();
    test_write_read();
    test_code_while_busy();
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire
